//--- verilog/fetch_pkg.sv
package fetch_pkg;

  // ==================================================
  // sizes
  // ==================================================

  // number of entries in the line store.
  localparam int fetch_depth = 8;

  // entry select bits, taken from address bits index_width+1 down to 2.
  localparam int index_width = 3;

  // prefetch stops once this many halfwords are waiting.
  localparam int fill_limit = 2 * fetch_depth - 2;

  // privilege mode after reset is machine mode.
  localparam logic [1:0] reset_mode = 2'd3;

  // ==================================================
  // vector types
  // ==================================================

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [index_width-1:0] index_t;
  typedef logic [index_width+1:0] count_t;
  typedef logic [29:0] tag_t;
  typedef logic [1:0] mode_t;

  // error bit on top, then the word tag, then the instruction word.
  typedef logic [62:0] entry_t;

  // ==================================================
  // controller states
  // ==================================================

  // redirect_wait holds a redirect or fence until no memory answer is
  // still on its way.
  typedef enum logic [1:0] {
    idle,
    active,
    redirect_wait,
    flush
  } fetch_state_t;

endpackage

//--- verilog/line_store_if.sv
`timescale 1ns/1ns

// one write port and two read ports of the fetch line store.
// the read data follows the read addresses in the same cycle.
interface line_store_if;

  logic wen;
  fetch_pkg::index_t waddr;
  fetch_pkg::entry_t wdata;
  fetch_pkg::index_t raddr1;
  fetch_pkg::index_t raddr2;
  fetch_pkg::entry_t rdata1;
  fetch_pkg::entry_t rdata2;

  modport ctrl (
    output wen,
    output waddr,
    output wdata,
    output raddr1,
    output raddr2,
    input rdata1,
    input rdata2
  );

  modport store (
    input wen,
    input waddr,
    input wdata,
    input raddr1,
    input raddr2,
    output rdata1,
    output rdata2
  );

endinterface

//--- verilog/fetch_line_store.sv
`timescale 1ns/1ns

module fetch_line_store (
  input logic clock,
  line_store_if.store store
);

  // ==================================================
  // entry array
  // ==================================================

  // entries start out as zero so the first tag compares see known data.
  fetch_pkg::entry_t entries [fetch_pkg::fetch_depth] = '{default: '0};

  // two independent read ports, one per word of a straddling instruction.
  assign store.rdata1 = entries[store.raddr1];
  assign store.rdata2 = entries[store.raddr2];

  always_ff @(posedge clock) begin
    if (store.wen) begin
      entries[store.waddr] <= store.wdata;
    end
  end

  // ==================================================
  // checks
  // ==================================================

  // the controller builds waddr from the prefetch address or the clear
  // counter, so an unknown index means its state was never reset.
  waddr_known_check : assert property (
    @(posedge clock) store.wen |-> !$isunknown(store.waddr)
  );

endmodule

//--- verilog/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic fetch_fence,
  input logic fetch_redirect,
  input fetch_pkg::addr_t fetch_addr,
  input fetch_pkg::mode_t fetch_mode,
  output fetch_pkg::word_t fetch_rdata,
  output logic fetch_error,
  output logic fetch_ready,
  output logic imem_valid,
  output fetch_pkg::addr_t imem_addr,
  output fetch_pkg::mode_t imem_mode,
  input fetch_pkg::word_t imem_rdata,
  input logic imem_error,
  input logic imem_ready,
  line_store_if.ctrl store
);

  fetch_pkg::fetch_state_t state, state_n;
  logic [fetch_pkg::fetch_depth-1:0] live, live_n;
  fetch_pkg::count_t count, count_base, count_n;
  fetch_pkg::addr_t addr, addr_n;
  fetch_pkg::mode_t mode, mode_n;
  fetch_pkg::index_t flush_index, flush_index_n;
  logic pend_fence, pend_fence_n;
  logic pend_redirect, pend_redirect_n;
  logic in_flight;

  fetch_pkg::addr_t req_addr1, req_addr1_n;
  fetch_pkg::addr_t req_addr2, req_addr2_n;
  fetch_pkg::mode_t pend_mode, pend_mode_n;

  logic strobe;
  logic halt;
  logic capture;
  logic full;
  logic wen;
  fetch_pkg::index_t waddr;
  fetch_pkg::entry_t wdata;
  logic hit1, hit2, whit1, whit2;
  fetch_pkg::entry_t first, second;
  fetch_pkg::count_t step;

  // ==================================================
  // state, prefetch and redirect
  // ==================================================

  always_comb begin
    state_n = state;
    live_n = live;
    count_base = count;
    addr_n = addr;
    mode_n = mode;
    flush_index_n = flush_index;
    pend_fence_n = pend_fence;
    pend_redirect_n = pend_redirect;
    pend_mode_n = pend_mode;
    req_addr1_n = req_addr1;
    req_addr2_n = req_addr2;
    strobe = 1'b0;
    halt = 1'b0;
    capture = 1'b0;
    wen = 1'b0;
    waddr = '0;
    wdata = '0;

    case (state)
      fetch_pkg::idle: begin
        halt = 1'b1;
        state_n = fetch_pkg::active;
      end
      fetch_pkg::active: begin
        if (fetch_valid) begin
          req_addr1_n = fetch_addr;
          req_addr2_n = fetch_addr + 32'd4;
          if (fetch_fence || fetch_redirect) begin
            // nothing buffered so far is usable after the change.
            pend_fence_n = fetch_fence;
            pend_redirect_n = fetch_redirect;
            pend_mode_n = fetch_mode;
            live_n = '0;
            count_base = '0;
            state_n = fetch_pkg::redirect_wait;
          end else begin
            strobe = 1'b1;
          end
        end
      end
      fetch_pkg::redirect_wait: begin
        halt = 1'b1;
      end
      fetch_pkg::flush: begin
        halt = 1'b1;
        wen = 1'b1;
        waddr = flush_index;
        if (flush_index == fetch_pkg::index_t'(fetch_pkg::fetch_depth - 1)) begin
          flush_index_n = '0;
          state_n = fetch_pkg::active;
        end else begin
          flush_index_n = flush_index + 1'b1;
        end
      end
      default: begin
        halt = 1'b1;
        state_n = fetch_pkg::idle;
      end
    endcase

    // an answer is only kept while prefetch runs undisturbed.
    if (imem_ready && state == fetch_pkg::active && state_n == fetch_pkg::active) begin
      capture = 1'b1;
      wen = 1'b1;
      waddr = addr[fetch_pkg::index_width+1:2];
      wdata = {imem_error, addr[31:2], imem_rdata};
      live_n[waddr] = 1'b1;
      addr_n = addr + 32'd4;
      count_base = count + fetch_pkg::count_t'(2);
    end

    // the change takes effect once no memory answer can still arrive.
    if (state_n == fetch_pkg::redirect_wait && (imem_ready || !in_flight)) begin
      if (pend_redirect_n) begin
        mode_n = pend_mode_n;
        addr_n = {req_addr1_n[31:2], 2'b00};
      end
      state_n = pend_fence_n ? fetch_pkg::flush : fetch_pkg::active;
      halt = pend_fence_n;
      pend_fence_n = 1'b0;
      pend_redirect_n = 1'b0;
    end
  end

  assign store.wen = wen;
  assign store.waddr = waddr;
  assign store.wdata = wdata;
  assign store.raddr1 = req_addr1_n[fetch_pkg::index_width+1:2];
  assign store.raddr2 = req_addr2_n[fetch_pkg::index_width+1:2];

  // ==================================================
  // hit and instruction alignment
  // ==================================================

  always_comb begin
    hit1 = live[store.raddr1] && (store.rdata1[61:32] == req_addr1_n[31:2]);
    hit2 = live[store.raddr2] && (store.rdata2[61:32] == req_addr2_n[31:2]);
    whit1 = capture && (wdata[61:32] == req_addr1_n[31:2]);
    whit2 = capture && (wdata[61:32] == req_addr2_n[31:2]);
    first = whit1 ? wdata : store.rdata1;
    second = whit2 ? wdata : store.rdata2;
    fetch_rdata = '0;
    fetch_error = 1'b0;
    fetch_ready = 1'b0;
    step = '0;
    count_n = count_base;

    if (strobe && (whit1 || hit1)) begin
      if (!req_addr1_n[1]) begin
        fetch_rdata = first[31:0];
        fetch_error = first[62];
        fetch_ready = 1'b1;
      end else begin
        fetch_rdata[15:0] = first[31:16];
        fetch_error = first[62];
        if (!(&first[17:16])) begin
          fetch_ready = 1'b1;
        end else if (whit2 || hit2) begin
          // upper half of a straddling instruction sits in the next word.
          fetch_rdata[31:16] = second[15:0];
          fetch_error = second[62];
          fetch_ready = 1'b1;
        end
      end
    end

    if (fetch_ready) begin
      if (&fetch_rdata[1:0]) begin
        step = fetch_pkg::count_t'(2);
      end else begin
        fetch_rdata[31:16] = '0;
        step = fetch_pkg::count_t'(1);
      end
      if (step <= count_base) begin
        count_n = count_base - step;
      end
    end
  end

  assign full = count_n >= fetch_pkg::count_t'(fetch_pkg::fill_limit);
  assign imem_valid = !full && !halt;
  assign imem_addr = addr_n;
  assign imem_mode = mode_n;

  // ==================================================
  // registers
  // ==================================================

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fetch_pkg::idle;
      live <= '0;
      count <= '0;
      addr <= '0;
      mode <= fetch_pkg::reset_mode;
      flush_index <= '0;
      pend_fence <= 1'b0;
      pend_redirect <= 1'b0;
      in_flight <= 1'b0;
    end else begin
      state <= state_n;
      live <= live_n;
      count <= count_n;
      addr <= addr_n;
      mode <= mode_n;
      flush_index <= flush_index_n;
      pend_fence <= pend_fence_n;
      pend_redirect <= pend_redirect_n;
      in_flight <= imem_valid || (in_flight && !imem_ready);
    end
  end

  always_ff @(posedge clock) begin
    req_addr1 <= req_addr1_n;
    req_addr2 <= req_addr2_n;
    pend_mode <= pend_mode_n;
  end

  // ==================================================
  // checks
  // ==================================================

  // the clear only starts after the last memory answer, and the core is
  // held off until every entry is written.
  flush_quiet_check : assert property (
    @(posedge clock) disable iff (!reset)
    (state == fetch_pkg::flush) |-> (!fetch_ready && !in_flight)
  );

  // prefetch stops short of the limit, so one answer in flight fits.
  count_bound_check : assert property (
    @(posedge clock) disable iff (!reset)
    count <= fetch_pkg::count_t'(2 * fetch_pkg::fetch_depth)
  );

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
  input logic clock,
  input logic reset,

  // core side
  input logic fetch_valid,
  input logic fetch_fence,
  input logic fetch_redirect,
  input fetch_pkg::addr_t fetch_addr,
  input fetch_pkg::mode_t fetch_mode,
  output fetch_pkg::word_t fetch_rdata,
  output logic fetch_error,
  output logic fetch_ready,

  // instruction memory side
  output logic imem_valid,
  output fetch_pkg::addr_t imem_addr,
  output fetch_pkg::mode_t imem_mode,
  input fetch_pkg::word_t imem_rdata,
  input logic imem_error,
  input logic imem_ready
);

  // ==================================================
  // controller and line store
  // ==================================================

  line_store_if store_bus ();

  fetch_ctrl ctrl (
    .clock (clock),
    .reset (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_redirect (fetch_redirect),
    .fetch_addr (fetch_addr),
    .fetch_mode (fetch_mode),
    .fetch_rdata (fetch_rdata),
    .fetch_error (fetch_error),
    .fetch_ready (fetch_ready),
    .imem_valid (imem_valid),
    .imem_addr (imem_addr),
    .imem_mode (imem_mode),
    .imem_rdata (imem_rdata),
    .imem_error (imem_error),
    .imem_ready (imem_ready),
    .store (store_bus.ctrl)
  );

  // prefetched words that the controller looks up on each fetch strobe.
  fetch_line_store line_store (
    .clock (clock),
    .store (store_bus.store)
  );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ns

// 40 ns clock, with reset held low for the first 4 rising edges.
module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period = 20;
  localparam int reset_cycles = 4;

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b1;
  end

endmodule

//--- verif/fetch_imem_model.sv
`timescale 1ns/1ns

module fetch_imem_model (
  input logic clock,
  input logic reset,
  input logic imem_valid,
  input fetch_pkg::addr_t imem_addr,
  input fetch_pkg::mode_t imem_mode,
  output fetch_pkg::word_t imem_rdata,
  output logic imem_error,
  output logic imem_ready,
  output fetch_pkg::mode_t last_mode
);

  // 2 KB of image, enough for every address the golden file names.
  localparam int image_words = 512;
  localparam int index_top = $clog2(image_words) + 1;

  fetch_pkg::word_t image [image_words];
  logic error_flags [image_words];

  fetch_pkg::word_t rdata_q = '0;
  logic error_q = 1'b0;
  logic ready_q = 1'b0;
  fetch_pkg::mode_t mode_q = fetch_pkg::reset_mode;

  // words the golden file leaves out still differ from address to address.
  initial begin
    for (int i = 0; i < image_words; i++) begin
      image[i] = {~(30'(i)), 2'b11};
      error_flags[i] = 1'b0;
    end
  end

  task automatic load_word(input fetch_pkg::addr_t addr, input fetch_pkg::word_t data,
                           input logic error);
    image[addr[index_top:2]] = data;
    error_flags[addr[index_top:2]] = error;
  endtask

  // every sampled request is answered on the next cycle.
  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
      rdata_q <= '0;
      error_q <= 1'b0;
      mode_q <= fetch_pkg::reset_mode;
    end else begin
      ready_q <= imem_valid;
      if (imem_valid) begin
        rdata_q <= image[imem_addr[index_top:2]];
        error_q <= error_flags[imem_addr[index_top:2]];
        mode_q <= imem_mode;
      end
    end
  end

  assign imem_rdata = rdata_q;
  assign imem_error = error_q;
  assign imem_ready = ready_q;
  assign last_mode = mode_q;

endmodule

//--- verif/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb;

  logic clock, reset;
  logic fetch_valid, fetch_fence, fetch_redirect;
  fetch_pkg::addr_t fetch_addr;
  fetch_pkg::mode_t fetch_mode;
  fetch_pkg::word_t fetch_rdata;
  logic fetch_error, fetch_ready;
  logic imem_valid, imem_error, imem_ready;
  fetch_pkg::addr_t imem_addr;
  fetch_pkg::mode_t imem_mode, sampled_mode, expected_mode;
  fetch_pkg::word_t imem_rdata;
  logic redirected = 1'b0;

  string kinds[$];
  logic [31:0] field1[$], field2[$], field3[$];
  int cycles = 0;
  int cycle_limit = 0;
  int seed = 26;

  tb_clock_gen clock_gen (.clock(clock), .reset(reset));

  fetch_unit dut (
    .clock(clock), .reset(reset),
    .fetch_valid(fetch_valid), .fetch_fence(fetch_fence), .fetch_redirect(fetch_redirect),
    .fetch_addr(fetch_addr), .fetch_mode(fetch_mode), .fetch_rdata(fetch_rdata),
    .fetch_error(fetch_error), .fetch_ready(fetch_ready),
    .imem_valid(imem_valid), .imem_addr(imem_addr), .imem_mode(imem_mode),
    .imem_rdata(imem_rdata), .imem_error(imem_error), .imem_ready(imem_ready)
  );

  fetch_imem_model imem (
    .clock(clock), .reset(reset), .imem_valid(imem_valid), .imem_addr(imem_addr),
    .imem_mode(imem_mode), .imem_rdata(imem_rdata), .imem_error(imem_error),
    .imem_ready(imem_ready), .last_mode(sampled_mode)
  );

  task automatic stop_with(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      stop_with("timeout: the test steps did not finish in time");
    end
  end

  // a miss is strobed again after a random gap of 0 to 3 cycles.
  task automatic fetch_until_ready(input fetch_pkg::addr_t addr, input fetch_pkg::word_t data,
                                   input logic error);
    int gap;
    logic served;
    served = 1'b0;
    while (!served) begin
      @(posedge clock);
      #2;
      fetch_valid = 1'b1;
      fetch_addr = addr;
      @(negedge clock);
      served = fetch_ready;
      gap = {$random(seed)} % 4;
      if (served) begin
        check("fetch_rdata", fetch_rdata, data);
        check("fetch_error", 32'(fetch_error), 32'(error));
        if (redirected) begin
          check("imem_mode", 32'(sampled_mode), 32'(expected_mode));
        end
      end
      if (served || gap > 0) begin
        @(posedge clock);
        #2;
        fetch_valid = 1'b0;
        if (!served) begin
          repeat (gap - 1) @(posedge clock);
        end
      end
    end
  endtask

  // a redirect or fence is done once prefetch requests start again.
  task automatic send_control(input logic is_fence, input fetch_pkg::addr_t addr,
                              input fetch_pkg::mode_t mode);
    @(posedge clock);
    #2;
    fetch_valid = 1'b1;
    fetch_fence = is_fence;
    fetch_redirect = !is_fence;
    fetch_addr = addr;
    fetch_mode = mode;
    @(posedge clock);
    #2;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_redirect = 1'b0;
    @(negedge clock);
    while (!imem_valid) @(negedge clock);
  endtask

  task automatic count_idle_answers(input int quiet_cycles, input int max_responses);
    int responses;
    responses = 0;
    repeat (quiet_cycles) begin
      if (imem_ready) responses++;
      @(negedge clock);
    end
    if (responses > max_responses) begin
      stop_with($sformatf("prefetch kept going: %0d memory answers while idle", responses));
    end
  endtask

  initial begin
    int fd;
    int code;
    string kind;
    string rest;
    logic [31:0] a, b, c;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_redirect = 1'b0;
    fetch_addr = '0;
    fetch_mode = '0;
    expected_mode = fetch_pkg::reset_mode;
    fd = $fopen("verif/fetch_golden.txt", "r");
    if (fd == 0) stop_with("could not open verif/fetch_golden.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      c = '0;
      if (kind.substr(0, 0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        if (kind == "mem" || kind == "fetch") code = $fscanf(fd, "%h %h %h", a, b, c) - 1;
        else if (kind == "redirect" || kind == "fence") code = $fscanf(fd, "%h %h", a, b);
        else if (kind == "quiet") code = $fscanf(fd, "%d %d", a, b);
        else stop_with($sformatf("unknown line kind %s in the golden file", kind));
        if (code != 2) stop_with("a golden file line has missing fields");
        kinds.push_back(kind);
        field1.push_back(a);
        field2.push_back(b);
        field3.push_back(c);
      end
    end
    $fclose(fd);
    cycle_limit = 40 * kinds.size() + 100;

    wait (reset === 1'b1);
    foreach (kinds[i]) begin
      if (kinds[i] == "mem") begin
        imem.load_word(field1[i], field2[i], field3[i][0]);
      end else if (kinds[i] == "fetch") begin
        fetch_until_ready(field1[i], field2[i], field3[i][0]);
      end else if (kinds[i] == "redirect") begin
        expected_mode = field2[i][1:0];
        redirected = 1'b1;
        send_control(1'b0, field1[i], field2[i][1:0]);
      end else if (kinds[i] == "fence") begin
        send_control(1'b1, field1[i], field2[i][1:0]);
      end else begin
        count_idle_answers(int'(field1[i]), int'(field2[i]));
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verif/fetch_golden.txt
# kind address value error
# mem: image word and error flag, fetch: expected word and error, redirect/fence: mode
mem 00000100 00500093 0
mem 00000104 00a00113 0
mem 00000108 002081b3 0
mem 0000010c 40310233 0
mem 00000200 00934505 0
mem 00000204 808200a0 0
mem 00000208 00000013 0
mem 00000300 00100073 0
mem 00000304 30200073 1
mem 00000308 0000006f 0
mem 00000400 00000513 0
mem 00000404 00b50533 0
mem 00000500 11111113 0
mem 00000504 22222213 0
redirect 00000100 0
fetch 00000100 00500093 0
fetch 00000104 00a00113 0
fetch 00000108 002081b3 0
fetch 0000010c 40310233 0
redirect 00000200 1
fetch 00000200 00004505 0
fetch 00000202 00a00093 0
fetch 00000206 00008082 0
fetch 00000208 00000013 0
redirect 00000300 3
fetch 00000300 00100073 0
fetch 00000304 30200073 1
fetch 00000308 0000006f 0
redirect 00000400 2
quiet 50 7
fetch 00000400 00000513 0
fetch 00000404 00b50533 0
redirect 00000500 0
fetch 00000500 11111113 0
fetch 00000504 22222213 0
fence 00000000 0
mem 00000500 33333313 0
mem 00000504 44444413 0
redirect 00000500 0
fetch 00000500 33333313 0
fetch 00000504 44444413 0

//--- list.f
verilog/fetch_pkg.sv
verilog/line_store_if.sv
verilog/fetch_line_store.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
verif/tb_clock_gen.sv
verif/fetch_imem_model.sv
verif/fetch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module fetch_unit_tb -o fetch_sim \
  && ./obj_dir/fetch_sim | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
